// File: hw/trigger_cfg_pkg.sv
// Trigger path configuration

package trigger_cfg_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------
    localparam int NUM_CHAN    = 5;   // channel FPGAs
    localparam int TRIG_NUM_W  = 24;  // global trigger number
    localparam int TIMESTAMP_W = 44;  // free-running ttc_clk count
    localparam int TRIG_TYPE_W = 5;   // muon fill, laser, pedestal ...
    localparam int DELAY_W     = 8;   // trigger delay in ttc_clk cycles

    // ----------------------------------------
    // named vectors
    // ----------------------------------------
    typedef logic [NUM_CHAN-1:0]    chan_mask_t;  // one bit per channel
    typedef logic [TRIG_NUM_W-1:0]  trig_num_t;
    typedef logic [TRIG_TYPE_W-1:0] trig_type_t;
    typedef logic [TIMESTAMP_W-1:0] timestamp_t;

endpackage

// File: hw/trigger_pkg.sv
// Trigger record types

package trigger_pkg;

    // ----------------------------------------
    // trigger FIFO payload
    // ----------------------------------------
    // written by the receiver on every accepted trigger
    typedef struct packed {
        trigger_cfg_pkg::timestamp_t timestamp;  // counter value at the sample edge
        trigger_cfg_pkg::trig_num_t  trig_num;   // starts at 1
        trigger_cfg_pkg::trig_type_t trig_type;  // as sampled with the trigger
    } trig_info_t;

    // ----------------------------------------
    // acquisition FIFO payload
    // ----------------------------------------
    // logged by the acquisition controller once all channels report done
    typedef struct packed {
        trigger_cfg_pkg::trig_num_t  trig_num;   // copy of the number handed over
        trigger_cfg_pkg::trig_type_t trig_type;  // copy of the type handed over
    } acq_event_t;

endpackage

// File: hw/ttc_trigger_receiver.sv
// TTC trigger receiver
`timescale 1ns/1ps

module ttc_trigger_receiver (
    input  logic ttc_clk,
    input  logic rst,
    input  logic rst_trigger_num,        // from TTC channel B
    input  logic rst_trigger_timestamp,  // from TTC channel B

    // trigger input
    input  logic ttc_trigger,
    input  trigger_cfg_pkg::trig_type_t trig_type,

    // acquisition controller side
    input  logic acq_ready,                          // controller idle
    output logic acq_valid,
    output trigger_cfg_pkg::trig_num_t  acq_trig_num,
    output trigger_cfg_pkg::trig_type_t acq_trig_type,

    // trigger FIFO side
    input  logic trig_ready,
    output logic trig_valid,
    output trigger_pkg::trig_info_t trig_data,

    // status
    output trigger_cfg_pkg::trig_num_t  trig_num,       // last number assigned
    output trigger_cfg_pkg::timestamp_t trig_timestamp, // of last accepted trigger
    output logic error_trig_rate                        // sticky until rst
);

    logic trig_d;                           // ttc_trigger one edge ago
    logic trig_rise;
    logic accept;
    logic issue;                            // both transfers this cycle
    trigger_cfg_pkg::timestamp_t ts_cnt;
    trigger_cfg_pkg::trig_num_t  num_next;

    assign trig_rise = ttc_trigger & ~trig_d;
    assign accept    = trig_rise & acq_ready & trig_ready;  // both sinks must take it
    // a number reset in the same cycle still hands out 1
    assign num_next  = rst_trigger_num ? trigger_cfg_pkg::trig_num_t'(1) : trig_num + 1'b1;

    // ----------------------------------------
    // edge detect and counters
    // ----------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            trig_d <= 1'b0;
        end else begin
            trig_d <= ttc_trigger;
        end
    end

    always_ff @(posedge ttc_clk) begin
        if (rst || rst_trigger_timestamp) begin
            ts_cnt <= '0;                   // 0 in the following cycle
        end else begin
            ts_cnt <= ts_cnt + 1'b1;
        end
    end

    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            trig_num <= '0;
        end else if (accept) begin
            trig_num <= num_next;
        end else if (rst_trigger_num) begin
            trig_num <= '0;                 // next accepted gets 1
        end
    end

    // ----------------------------------------
    // record, handshake, rate error
    // ----------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            trig_data       <= '0;
            issue           <= 1'b0;
            error_trig_rate <= 1'b0;
        end else begin
            issue <= accept;                // one-cycle valid, sinks are guaranteed ready
            if (accept) begin
                trig_data <= '{timestamp: ts_cnt, trig_num: num_next, trig_type: trig_type};
            end
            if (trig_rise && !(acq_ready && trig_ready)) begin
                error_trig_rate <= 1'b1;    // refused, number not consumed
            end
        end
    end

    assign acq_valid      = issue;
    assign trig_valid     = issue;
    assign acq_trig_num   = trig_data.trig_num;
    assign acq_trig_type  = trig_data.trig_type;
    assign trig_timestamp = trig_data.timestamp;

endmodule

// File: hw/trigger_fifo.sv
// Synchronous valid/ready FIFO
`timescale 1ns/1ps

module trigger_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  FIFO_DEPTH = 16          // power of two, 2 or more
) (
    input  logic ttc_clk,
    input  logic rst,

    // write side
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,             // low when full

    // read side
    output logic     out_valid,            // high when not empty
    output payload_t out_data,
    input  logic     out_ready
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    payload_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;                // 0 .. FIFO_DEPTH
    logic wr_en;
    logic rd_en;

    assign in_ready  = (count != (PTR_W+1)'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign wr_en     = in_valid & in_ready;
    assign rd_en     = out_valid & out_ready;
    assign out_data  = mem[rd_ptr];         // visible the cycle after write

    // ----------------------------------------
    // pointers and fill level
    // ----------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // none or both
            endcase
        end
    end

    // storage
    always_ff @(posedge ttc_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // a write into a full FIFO or a read from an empty one drives the level out of range
    a_level_range: assert property (@(posedge ttc_clk) disable iff (rst)
        count <= (PTR_W+1)'(FIFO_DEPTH));

    // pointer distance tracks the fill level
    a_ptr_level: assert property (@(posedge ttc_clk) disable iff (rst)
        (wr_ptr - rd_ptr) == count[PTR_W-1:0]);

endmodule

// File: hw/channel_acq_controller.sv
// Channel acquisition controller
`timescale 1ns/1ps

module channel_acq_controller (
    input  logic ttc_clk,
    input  logic rst,

    // configuration
    input  trigger_cfg_pkg::chan_mask_t chan_en,                // channels to trigger
    input  logic [trigger_cfg_pkg::DELAY_W-1:0] trig_delay,     // cycles before the pulse

    // from the trigger receiver
    input  logic acq_valid,
    input  trigger_cfg_pkg::trig_num_t  acq_trig_num,
    input  trigger_cfg_pkg::trig_type_t acq_trig_type,
    output logic acq_ready,                                     // high only when idle

    // channel FPGAs
    input  trigger_cfg_pkg::chan_mask_t chan_dones,
    output trigger_cfg_pkg::chan_mask_t chan_enable,
    output trigger_cfg_pkg::chan_mask_t chan_trig,              // one-cycle pulse

    // to the acquisition FIFO
    output logic event_valid,
    output trigger_pkg::acq_event_t event_data,
    input  logic event_ready
);

    typedef enum logic [1:0] {
        IDLE,
        DELAY,      // counting down trig_delay
        ACQUIRE,    // pulse sent, gathering done bits
        LOG         // event offered to the FIFO
    } state_t;

    state_t state;
    logic [trigger_cfg_pkg::DELAY_W-1:0] delay_cnt;
    trigger_cfg_pkg::chan_mask_t mask;          // enabled set for this trigger
    trigger_cfg_pkg::chan_mask_t done_seen;     // sticky
    trigger_cfg_pkg::chan_mask_t done_hit;
    logic all_done;
    logic take;

    assign take        = (state == IDLE) & acq_valid;
    // a channel cannot be done in its own trigger cycle, ignores stale levels
    assign done_hit    = chan_dones & mask & ~chan_trig;
    assign all_done    = ((done_seen | done_hit) == mask);
    assign acq_ready   = (state == IDLE);
    assign event_valid = (state == LOG);

    // ----------------------------------------
    // control FSM
    // ----------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            state       <= IDLE;
            delay_cnt   <= '0;
            done_seen   <= '0;
            chan_enable <= '0;
            chan_trig   <= '0;
        end else begin
            chan_trig <= '0;                        // pulse lasts one cycle
            case (state)
                IDLE: begin
                    if (acq_valid) begin
                        chan_enable <= chan_en;     // up in the next cycle
                        done_seen   <= '0;
                        if (trig_delay == '0) begin
                            chan_trig <= chan_en;   // no delay, fire with enable
                            state     <= ACQUIRE;
                        end else begin
                            delay_cnt <= trig_delay;
                            state     <= DELAY;
                        end
                    end
                end
                DELAY: begin
                    delay_cnt <= delay_cnt - 1'b1;
                    if (delay_cnt == trigger_cfg_pkg::DELAY_W'(1)) begin
                        chan_trig <= mask;
                        state     <= ACQUIRE;
                    end
                end
                ACQUIRE: begin
                    done_seen <= done_seen | done_hit;
                    if (all_done) begin
                        chan_enable <= '0;          // drops as the event goes out
                        state       <= LOG;
                    end
                end
                LOG: begin
                    if (event_ready) state <= IDLE; // ready again next cycle
                end
                default: state <= IDLE;
            endcase
        end
    end

    // latched trigger fields
    always_ff @(posedge ttc_clk) begin
        if (take) begin
            mask       <= chan_en;
            event_data <= '{trig_num: acq_trig_num, trig_type: acq_trig_type};
        end
    end

    // pulse never reaches a channel outside the latched set
    a_trig_in_mask: assert property (@(posedge ttc_clk) disable iff (rst)
        (chan_trig & ~mask) == '0);

endmodule

// File: hw/trigger_processor.sv
// Trigger processor
`timescale 1ns/1ps

module trigger_processor (
    input  logic ttc_clk,
    input  logic rst,

    // trigger FIFO
    input  logic trig_valid,
    input  trigger_pkg::trig_info_t trig_data,
    output logic trig_ready,

    // acquisition FIFO
    input  logic event_valid,
    input  trigger_pkg::acq_event_t event_data,
    output logic event_ready,

    // command manager
    input  logic readout_ready,                         // manager idle
    input  logic readout_done,                          // one-cycle pulse
    output logic readout_valid,
    output trigger_cfg_pkg::trig_num_t  ttc_trig_num,   // global number
    output trigger_cfg_pkg::trig_num_t  ttc_event_num,  // number logged by the channels
    output trigger_cfg_pkg::trig_type_t ttc_trig_type,
    output trigger_cfg_pkg::timestamp_t ttc_trig_timestamp,

    // sticky errors
    output logic error_trig_num,
    output logic error_trig_type
);

    typedef enum logic [1:0] {
        IDLE,
        OFFER,      // readout_valid up
        WAIT_DONE   // readout running
    } state_t;

    state_t state;
    logic pop;

    // both FIFOs popped together
    assign pop           = (state == IDLE) & trig_valid & event_valid;
    assign trig_ready    = pop;
    assign event_ready   = pop;
    assign readout_valid = (state == OFFER);

    // ----------------------------------------
    // readout FSM and checks
    // ----------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            state           <= IDLE;
            error_trig_num  <= 1'b0;
            error_trig_type <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (pop) begin
                        state <= OFFER;
                        if (trig_data.trig_num != event_data.trig_num) error_trig_num <= 1'b1;
                        if (trig_data.trig_type != event_data.trig_type) error_trig_type <= 1'b1;
                    end
                end
                OFFER:     if (readout_ready) state <= WAIT_DONE;
                WAIT_DONE: if (readout_done) state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    // popped pair
    always_ff @(posedge ttc_clk) begin
        if (pop) begin
            ttc_trig_num       <= trig_data.trig_num;
            ttc_event_num      <= event_data.trig_num;
            ttc_trig_type      <= trig_data.trig_type;
            ttc_trig_timestamp <= trig_data.timestamp;
        end
    end

    // record and valid hold while the manager stalls
    a_offer_stable: assert property (@(posedge ttc_clk) disable iff (rst)
        (readout_valid && !readout_ready) |=> readout_valid &&
        $stable({ttc_trig_num, ttc_event_num, ttc_trig_type, ttc_trig_timestamp}));

endmodule

// File: hw/trigger_top.sv
// Trigger manager top
`timescale 1ns/1ps

module trigger_top #(
    parameter int FIFO_DEPTH = 16               // both FIFOs
) (
    input  logic ttc_clk,
    input  logic rst,
    input  logic rst_trigger_num,               // TTC channel B
    input  logic rst_trigger_timestamp,         // TTC channel B

    // trigger and configuration
    input  logic ttc_trigger,
    input  trigger_cfg_pkg::trig_type_t trig_type,
    input  trigger_cfg_pkg::chan_mask_t chan_en,
    input  logic [trigger_cfg_pkg::DELAY_W-1:0] trig_delay,

    // channel FPGAs
    input  trigger_cfg_pkg::chan_mask_t chan_dones,
    output trigger_cfg_pkg::chan_mask_t chan_enable,
    output trigger_cfg_pkg::chan_mask_t chan_trig,

    // command manager
    input  logic readout_ready,
    input  logic readout_done,
    output logic readout_valid,
    output trigger_cfg_pkg::trig_num_t  ttc_trig_num,
    output trigger_cfg_pkg::trig_num_t  ttc_event_num,
    output trigger_cfg_pkg::trig_type_t ttc_trig_type,
    output trigger_cfg_pkg::timestamp_t ttc_trig_timestamp,

    // status and errors
    output trigger_cfg_pkg::trig_num_t  trig_num,
    output trigger_cfg_pkg::timestamp_t trig_timestamp,
    output logic trig_fifo_full,
    output logic acq_fifo_full,
    output logic acq_busy,
    output logic error_trig_rate,
    output logic error_trig_num,
    output logic error_trig_type
);

    // ----------------------------------------
    // internal links
    // ----------------------------------------
    logic acq_valid, acq_ready;
    trigger_cfg_pkg::trig_num_t  acq_trig_num;
    trigger_cfg_pkg::trig_type_t acq_trig_type;
    logic trig_in_valid, trig_in_ready, trig_out_valid, trig_out_ready;
    trigger_pkg::trig_info_t trig_in_data, trig_out_data;
    logic evt_in_valid, evt_in_ready, evt_out_valid, evt_out_ready;
    trigger_pkg::acq_event_t evt_in_data, evt_out_data;

    assign trig_fifo_full = ~trig_in_ready;
    assign acq_fifo_full  = ~evt_in_ready;
    assign acq_busy       = ~acq_ready;

    ttc_trigger_receiver ttc_trigger_receiver_i (
        .ttc_clk, .rst, .rst_trigger_num, .rst_trigger_timestamp,
        .ttc_trigger, .trig_type,
        .acq_ready, .acq_valid, .acq_trig_num, .acq_trig_type,
        .trig_ready(trig_in_ready), .trig_valid(trig_in_valid), .trig_data(trig_in_data),
        .trig_num, .trig_timestamp, .error_trig_rate
    );

    // timestamp, number and type per accepted trigger
    trigger_fifo #(.payload_t(trigger_pkg::trig_info_t), .FIFO_DEPTH(FIFO_DEPTH)) trig_fifo_i (
        .ttc_clk, .rst,
        .in_valid(trig_in_valid), .in_data(trig_in_data), .in_ready(trig_in_ready),
        .out_valid(trig_out_valid), .out_data(trig_out_data), .out_ready(trig_out_ready)
    );

    channel_acq_controller channel_acq_controller_i (
        .ttc_clk, .rst, .chan_en, .trig_delay,
        .acq_valid, .acq_trig_num, .acq_trig_type, .acq_ready,
        .chan_dones, .chan_enable, .chan_trig,
        .event_valid(evt_in_valid), .event_data(evt_in_data), .event_ready(evt_in_ready)
    );

    // number and type per completed acquisition
    trigger_fifo #(.payload_t(trigger_pkg::acq_event_t), .FIFO_DEPTH(FIFO_DEPTH)) acq_fifo_i (
        .ttc_clk, .rst,
        .in_valid(evt_in_valid), .in_data(evt_in_data), .in_ready(evt_in_ready),
        .out_valid(evt_out_valid), .out_data(evt_out_data), .out_ready(evt_out_ready)
    );

    trigger_processor trigger_processor_i (
        .ttc_clk, .rst,
        .trig_valid(trig_out_valid), .trig_data(trig_out_data), .trig_ready(trig_out_ready),
        .event_valid(evt_out_valid), .event_data(evt_out_data), .event_ready(evt_out_ready),
        .readout_ready, .readout_done, .readout_valid,
        .ttc_trig_num, .ttc_event_num, .ttc_trig_type, .ttc_trig_timestamp,
        .error_trig_num, .error_trig_type
    );

endmodule

// File: tb/trigger_top_tb.sv
// Trigger manager testbench
`timescale 1ns/1ps

module trigger_top_tb;

    localparam int CLK_PERIOD = 100;
    localparam int SEED       = 64;
    localparam int FIFO_DEPTH = 16;
    localparam int MAX_DELAY  = 15;     // trig_delay range used here
    localparam int N_RANDOM   = 40;
    localparam int N_HOLD     = 20;     // enough to fill both FIFOs
    localparam int N_RESET    = 4;
    localparam int N_TRIG     = N_RANDOM + 2 + N_HOLD + 2 * N_RESET;
    localparam int REC_W      = 2 * trigger_cfg_pkg::TRIG_NUM_W + trigger_cfg_pkg::TRIG_TYPE_W
                                + trigger_cfg_pkg::TIMESTAMP_W;

    // DUT inputs
    logic ttc_clk, rst, rst_trigger_num, rst_trigger_timestamp, ttc_trigger;
    trigger_cfg_pkg::trig_type_t trig_type;
    trigger_cfg_pkg::chan_mask_t chan_en, chan_dones;
    logic [trigger_cfg_pkg::DELAY_W-1:0] trig_delay;
    logic readout_ready, readout_done;
    // DUT outputs
    trigger_cfg_pkg::chan_mask_t chan_enable, chan_trig;
    logic readout_valid, trig_fifo_full, acq_fifo_full, acq_busy;
    trigger_cfg_pkg::trig_num_t  ttc_trig_num, ttc_event_num, trig_num;
    trigger_cfg_pkg::trig_type_t ttc_trig_type;
    trigger_cfg_pkg::timestamp_t ttc_trig_timestamp, trig_timestamp;
    logic error_trig_rate, error_trig_num, error_trig_type;

    // ----------------------------------------
    // reference model state
    // ----------------------------------------
    trigger_pkg::trig_info_t exp_q[$];          // records still owed by the DUT
    trigger_cfg_pkg::timestamp_t model_ts;
    trigger_cfg_pkg::timestamp_t model_last_ts; // timestamp of the last accepted trigger
    trigger_cfg_pkg::trig_num_t  model_num;     // last number handed out
    trigger_cfg_pkg::chan_mask_t exp_en;
    logic prev_trigger, exp_rate_err, take_pending, held, fifo_full_seen, acq_full_seen;
    logic hold_ready;                           // forces readout_ready low
    logic [REC_W-1:0] held_rec;
    int trig_countdown;                         // negedges until chan_trig, -1 idle
    int value_errors, other_errors, records, accepted, refused;
    string test_name;

    trigger_top #(.FIFO_DEPTH(FIFO_DEPTH)) trigger_top_i (
        .ttc_clk, .rst, .rst_trigger_num, .rst_trigger_timestamp,
        .ttc_trigger, .trig_type, .chan_en, .trig_delay,
        .chan_dones, .chan_enable, .chan_trig,
        .readout_ready, .readout_done, .readout_valid,
        .ttc_trig_num, .ttc_event_num, .ttc_trig_type, .ttc_trig_timestamp,
        .trig_num, .trig_timestamp, .trig_fifo_full, .acq_fifo_full, .acq_busy,
        .error_trig_rate, .error_trig_num, .error_trig_type
    );

    initial begin
        ttc_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ttc_clk = ~ttc_clk;
    end

    task automatic report_value(input string what, input longint unsigned expected,
                                input longint unsigned actual);
        value_errors++;
        $display("error %s: %s expected 0x%0h actual 0x%0h at %0t",
                 test_name, what, expected, actual, $time);
    endtask

    task automatic report_failure(input string msg);
        other_errors++;
        $display("%s: %s at %0t", test_name, msg, $time);
    endtask

    // one-cycle trigger with fresh type and mask, then a quiet gap
    task automatic send_trigger(input int delay, input int gap);
        @(posedge ttc_clk);
        ttc_trigger <= 1'b1;
        trig_type   <= trigger_cfg_pkg::trig_type_t'($urandom);
        chan_en     <= trigger_cfg_pkg::chan_mask_t'($urandom);
        trig_delay  <= trigger_cfg_pkg::DELAY_W'(delay);
        @(posedge ttc_clk);
        ttc_trigger <= 1'b0;
        repeat (gap) @(posedge ttc_clk);
    endtask

    task automatic pulse_counter_reset(input logic num, input logic ts);
        @(posedge ttc_clk);
        rst_trigger_num       <= num;
        rst_trigger_timestamp <= ts;
        @(posedge ttc_clk);
        rst_trigger_num       <= 1'b0;
        rst_trigger_timestamp <= 1'b0;
    endtask

    task automatic drain_records;
        @(negedge ttc_clk);
        while (exp_q.size() != 0) @(negedge ttc_clk);   // watchdog bounds this
    endtask

    // ----------------------------------------
    // channel FPGAs: done bits 1 to 8 cycles after the pulse
    // ----------------------------------------
    initial begin
        trigger_cfg_pkg::chan_mask_t hit;
        int wait_n;
        chan_dones = '0;
        forever begin
            @(negedge ttc_clk);
            if (chan_trig != '0) begin
                hit    = chan_trig;
                wait_n = $urandom_range(8, 1);
                repeat (wait_n) @(posedge ttc_clk);
                chan_dones <= hit;
                @(negedge ttc_clk);
                while (chan_enable != '0) @(negedge ttc_clk);
                @(posedge ttc_clk);
                chan_dones <= '0;                       // clear before next trigger
            end
        end
    end

    // command manager: random ready, done pulse a few cycles after transfer
    initial begin
        int wait_n;
        readout_ready = 1'b0;
        readout_done  = 1'b0;
        forever begin
            @(negedge ttc_clk);
            if (readout_valid && readout_ready) begin
                @(posedge ttc_clk);                     // transfer edge
                readout_ready <= 1'b0;
                wait_n = $urandom_range(4, 1);
                repeat (wait_n) @(posedge ttc_clk);
                readout_done <= 1'b1;
                @(posedge ttc_clk);
                readout_done <= 1'b0;
            end else begin
                @(posedge ttc_clk);
                readout_ready <= !hold_ready && ($urandom_range(3, 0) != 0);
            end
        end
    end

    // ----------------------------------------
    // model and checks, at negedge where all signals are settled
    // ----------------------------------------
    always @(negedge ttc_clk) begin
        trigger_pkg::trig_info_t exp_rec;
        logic rise;
        if (rst) begin
            model_ts       = '0;
            model_last_ts  = '0;
            model_num      = '0;
            prev_trigger   = 1'b0;
            exp_rate_err   = 1'b0;
            take_pending   = 1'b0;
            held           = 1'b0;
            trig_countdown = -1;
            exp_q.delete();
        end else begin
            if (error_trig_rate !== exp_rate_err)
                report_value("error_trig_rate", exp_rate_err, error_trig_rate);
            if (error_trig_num !== 1'b0 || error_trig_type !== 1'b0)
                report_failure("processor flagged a number or type mismatch");
            if (trig_num !== model_num) report_value("trig_num", model_num, trig_num);
            if (trig_timestamp !== model_last_ts)
                report_value("trig_timestamp", model_last_ts, trig_timestamp);

            // channel pulse timing
            if (trig_countdown > 0) trig_countdown = trig_countdown - 1;
            if (trig_countdown >= 0 && chan_enable !== exp_en)
                report_value("chan_enable", exp_en, chan_enable);
            if (trig_countdown >= 0 && acq_busy !== 1'b1)
                report_failure("acq_busy low while a trigger is in progress");
            if (trig_countdown == 0) begin
                if (chan_trig !== exp_en) report_value("chan_trig", exp_en, chan_trig);
                trig_countdown = -1;
            end else if (chan_trig !== '0) begin
                report_value("chan_trig", 0, chan_trig);  // pulse at the wrong time
            end

            // readout records, in order and stable under a stall
            if (held && !readout_valid) report_failure("offered record withdrawn before transfer");
            if (readout_valid) begin
                if (held && {ttc_trig_num, ttc_event_num, ttc_trig_type, ttc_trig_timestamp}
                        !== held_rec)
                    report_failure("offered record changed while readout_ready was low");
                if (readout_ready) begin
                    held = 1'b0;
                    records++;
                    if (exp_q.size() == 0) begin
                        report_failure("record offered with no accepted trigger pending");
                    end else begin
                        exp_rec = exp_q.pop_front();
                        if (ttc_trig_num !== exp_rec.trig_num)
                            report_value("ttc_trig_num", exp_rec.trig_num, ttc_trig_num);
                        if (ttc_event_num !== exp_rec.trig_num)
                            report_value("ttc_event_num", exp_rec.trig_num, ttc_event_num);
                        if (ttc_trig_type !== exp_rec.trig_type)
                            report_value("ttc_trig_type", exp_rec.trig_type, ttc_trig_type);
                        if (ttc_trig_timestamp !== exp_rec.timestamp)
                            report_value("ttc_trig_timestamp", exp_rec.timestamp,
                                         ttc_trig_timestamp);
                    end
                end else begin
                    held     = 1'b1;
                    held_rec = {ttc_trig_num, ttc_event_num, ttc_trig_type, ttc_trig_timestamp};
                end
            end else begin
                held = 1'b0;
            end

            // acquisition FIFO never holds more than the trigger FIFO
            if (acq_fifo_full && !trig_fifo_full)
                report_failure("acquisition FIFO full while the trigger FIFO is not");

            // advance to the next edge
            if (trig_fifo_full) fifo_full_seen = 1'b1;
            if (acq_fifo_full) acq_full_seen = 1'b1;
            if (take_pending) begin                     // controller latches at this edge
                exp_en         = chan_en;
                trig_countdown = int'(trig_delay) + 1;
                take_pending   = 1'b0;
            end
            rise         = ttc_trigger && !prev_trigger;
            prev_trigger = ttc_trigger;
            if (rst_trigger_num) model_num = '0;
            if (rise) begin
                if (!acq_busy && !trig_fifo_full) begin
                    model_num     = model_num + 1'b1;
                    model_last_ts = model_ts;
                    exp_rec       = '{timestamp: model_ts, trig_num: model_num,
                                      trig_type: trig_type};
                    exp_q.push_back(exp_rec);
                    take_pending  = 1'b1;
                    accepted++;
                end else begin
                    exp_rate_err = 1'b1;                // refused, no number used
                    refused++;
                end
            end
            model_ts = rst_trigger_timestamp ? '0 : model_ts + 1'b1;
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        void'($urandom(SEED));
        test_name             = "reset";
        rst                   = 1'b1;
        rst_trigger_num       = 1'b0;
        rst_trigger_timestamp = 1'b0;
        ttc_trigger           = 1'b0;
        trig_type             = '0;
        chan_en               = '0;
        trig_delay            = '0;
        hold_ready            = 1'b0;
        fifo_full_seen        = 1'b0;
        acq_full_seen         = 1'b0;
        value_errors          = 0;
        other_errors          = 0;
        records               = 0;
        accepted              = 0;
        refused               = 0;
        repeat (5) @(posedge ttc_clk);
        rst <= 1'b0;

        test_name = "random";                           // short gaps give refusals too
        repeat (N_RANDOM) send_trigger($urandom_range(MAX_DELAY, 0), $urandom_range(25, 0));

        test_name = "refusal";
        @(negedge ttc_clk);
        while (acq_busy) @(negedge ttc_clk);
        send_trigger(MAX_DELAY, 2);
        send_trigger(MAX_DELAY, 40);                    // lands mid-delay

        test_name = "back_pressure";
        @(posedge ttc_clk);
        hold_ready <= 1'b1;
        repeat (N_HOLD) send_trigger($urandom_range(MAX_DELAY, 0), 35);
        hold_ready <= 1'b0;
        drain_records();

        test_name = "counter_reset";
        pulse_counter_reset(1'b1, 1'b0);
        repeat (N_RESET) send_trigger($urandom_range(MAX_DELAY, 0), 30);
        pulse_counter_reset(1'b0, 1'b1);
        repeat (N_RESET) send_trigger($urandom_range(MAX_DELAY, 0), 30);
        drain_records();
        repeat (10) @(posedge ttc_clk);

        test_name = "summary";
        if (refused == 0) report_failure("no trigger was refused");
        if (!fifo_full_seen) report_failure("trigger FIFO never filled under back-pressure");
        if (!acq_full_seen) report_failure("acquisition FIFO never filled under back-pressure");
        $display("records %0d, accepted %0d, refused %0d, value errors %0d, other errors %0d",
                 records, accepted, refused, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog sized from the trigger count
    initial begin
        #(N_TRIG * (MAX_DELAY + 40) * CLK_PERIOD);
        $display("timeout: run did not finish, %0d records still pending", exp_q.size());
        $display("Errors found");
        $finish;
    end

endmodule

// File: trigger_top.f
hw/trigger_cfg_pkg.sv
hw/trigger_pkg.sv
hw/ttc_trigger_receiver.sv
hw/trigger_fifo.sv
hw/channel_acq_controller.sv
hw/trigger_processor.sv
hw/trigger_top.sv
tb/trigger_top_tb.sv

// File: Bender.yml
package:
  name: trigger_top

sources:
  - hw/trigger_cfg_pkg.sv
  - hw/trigger_pkg.sv
  - hw/ttc_trigger_receiver.sv
  - hw/trigger_fifo.sv
  - hw/channel_acq_controller.sv
  - hw/trigger_processor.sv
  - hw/trigger_top.sv
  - target: test
    files:
      - tb/trigger_top_tb.sv
